//--- hw/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

    // ##################################################
    // major opcodes
    // ##################################################

    typedef enum logic [5:0] {
        SPECIAL = 6'h00,  // r-type, decoded by funct
        J       = 6'h02,
        JAL     = 6'h03,
        BEQ     = 6'h04,
        BNE     = 6'h05,
        ADDIU   = 6'h09,
        SLTI    = 6'h0a,
        SLTIU   = 6'h0b,
        ANDI    = 6'h0c,
        ORI     = 6'h0d,
        XORI    = 6'h0e,
        LUI     = 6'h0f,
        LW      = 6'h23,
        SW      = 6'h2b
    } opcode_e;

    // ##################################################
    // special opcode function codes
    // ##################################################

    typedef enum logic [5:0] {
        SLL     = 6'h00,
        SRL     = 6'h02,  // also rotr when bit 21 is set
        SRA     = 6'h03,
        SLLV    = 6'h04,
        SRLV    = 6'h06,
        SRAV    = 6'h07,
        JR      = 6'h08,
        JALR    = 6'h09,
        MOVZ    = 6'h0a,
        MOVN    = 6'h0b,
        SYSCALL = 6'h0c,
        MFHI    = 6'h10,
        MTHI    = 6'h11,
        MFLO    = 6'h12,
        MTLO    = 6'h13,
        MULT    = 6'h18,
        MULTU   = 6'h19,
        DIV     = 6'h1a,
        DIVU    = 6'h1b,
        ADDU    = 6'h21,
        SUBU    = 6'h23,
        AND     = 6'h24,
        OR      = 6'h25,
        XOR     = 6'h26,
        NOR     = 6'h27,
        SLT     = 6'h2a,
        SLTU    = 6'h2b
    } funct_e;

    typedef struct packed {
        logic [4:0] rd;
        logic [4:0] shamt;
        funct_e     funct;
    } rfmt_t;

    // the low half reads either as r-type fields or as the 16 bit immediate
    typedef union packed {
        rfmt_t       r;
        logic [15:0] imm;
    } low_t;

    typedef struct packed {
        opcode_e    op;
        logic [4:0] rs;
        logic [4:0] rt;
        low_t       low;
    } instr_fields_t;

endpackage

`default_nettype wire

//--- hw/ctl_sig_pkg.sv
`default_nettype none

package ctl_sig_pkg;

    // ##################################################
    // selectors
    // ##################################################

    typedef enum logic [1:0] {
        OPERAND_USE_NONE, OPERAND_USE_RS, OPERAND_USE_RT, OPERAND_USE_RS_RT
    } opd_use_e;

    typedef enum logic [2:0] {
        PC_SRC_SEQ, PC_SRC_BRANCH, PC_SRC_JUMP, PC_SRC_REGISTER, PC_SRC_EXCEPTION
    } pc_src_e;

    typedef enum logic [1:0] {EXC_NONE, EXC_SYSCALL, EXC_RESERVED} exc_chk_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU,
        ALU_SHIFT_LEFT, ALU_SHIFT_LOGIC_RIGHT, ALU_SHIFT_ARITH_RIGHT,
        ALU_ROTATE_RIGHT, ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {ALU_SRCA_RS, ALU_SRCA_RT, ALU_SRCA_SHAMT} alu_srca_e;

    typedef enum logic [1:0] {
        ALU_SRCB_RT, ALU_SRCB_IMM_SIGNED, ALU_SRCB_IMM_ZERO, ALU_SRCB_ZERO
    } alu_srcb_e;

    typedef enum logic [1:0] {REG_DST_NONE, REG_DST_RD, REG_DST_RT, REG_DST_R31} reg_dst_e;

    typedef enum logic [2:0] {
        REG_SRC_ALU, REG_SRC_MEM, REG_SRC_PCADD4, REG_SRC_RS, REG_SRC_HI, REG_SRC_LO
    } reg_src_e;

    typedef enum logic {REG_WRITE_ALWAYS, REG_WRITE_WHEN_FLAG} write_cond_e;
    typedef enum logic {FLAG_EQ, FLAG_NE} flag_sel_e;
    typedef enum logic {HILO_SRC_RS, HILO_SRC_MULDIV} hilo_src_e;

    typedef enum logic [2:0] {
        MULDIV_NCARE, MULDIV_MULT, MULDIV_MULTU, MULDIV_DIV, MULDIV_DIVU
    } muldiv_e;

    typedef enum logic [1:0] {MEM_OP_NONE, MEM_OP_LOAD, MEM_OP_STORE} mem_op_e;

    // ##################################################
    // control word
    // ##################################################

    typedef struct packed {
        opd_use_e    opd_use;
        pc_src_e     pc_src;
        exc_chk_e    exc_chk;
        alu_op_e     alu_op;
        alu_srca_e   alu_srca;
        alu_srcb_e   alu_srcb;
        reg_dst_e    reg_dst;
        reg_src_e    reg_src;
        write_cond_e write_cond;
        flag_sel_e   flag_sel;
        hilo_src_e   hilo_src;
        muldiv_e     muldiv;
        mem_op_e     mem_op;
        logic        reg_write;
        logic        write_hi;
        logic        write_lo;
    } control_t;

    function automatic control_t default_control();
        control_t c;
        c = '{OPERAND_USE_NONE, PC_SRC_SEQ, EXC_NONE, ALU_ADD, ALU_SRCA_RS, ALU_SRCB_RT,
              REG_DST_NONE, REG_SRC_ALU, REG_WRITE_ALWAYS, FLAG_EQ, HILO_SRC_RS,
              MULDIV_NCARE, MEM_OP_NONE, 1'b0, 1'b0, 1'b0};
        return c;
    endfunction

    // trap to the handler, nothing is read or written
    function automatic control_t reserved_control();
        control_t c;
        c = default_control();
        c.pc_src = PC_SRC_EXCEPTION;
        c.exc_chk = EXC_RESERVED;
        return c;
    endfunction

endpackage

`default_nettype wire

//--- hw/dec_if.sv
`timescale 1ns/10ps
`default_nettype none

interface dec_if import ctl_sig_pkg::*; ();

    control_t    ctl;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  dest;   // already resolved, 0 when nothing is written
    logic [4:0]  shamt;
    logic [15:0] imm;

    modport producer (output ctl, rs, rt, dest, shamt, imm);

    modport consumer (input ctl, rs, rt, dest, shamt, imm);

endinterface

`default_nettype wire

//--- hw/rtype_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module rtype_decoder import mips_isa_pkg::*, ctl_sig_pkg::*; #(
    parameter bit HAS_MULDIV = 1'b1
) (
    input  instr_fields_t fields,
    input  logic          rotate_bit,
    output control_t      ctl
);

    funct_e fn;

    assign fn = fields.low.r.funct;

    // write $rd from the given source, unconditionally
    function automatic control_t rd_write(control_t base, reg_src_e src);
        control_t c;
        c = base;
        c.reg_dst = REG_DST_RD;
        c.reg_src = src;
        c.reg_write = 1'b1;
        return c;
    endfunction

    always_comb begin
        ctl = default_control();

        case (fn)
            SLL, SRL, SRA, SLLV, SRLV, SRAV: begin
                ctl = rd_write(ctl, REG_SRC_ALU);
                ctl.alu_srcb = ALU_SRCB_RT;
                if (fn inside {SLLV, SRLV, SRAV}) begin
                    ctl.opd_use = OPERAND_USE_RS_RT;
                    ctl.alu_srca = ALU_SRCA_RS;   // shift amount comes from $rs
                end else begin
                    ctl.opd_use = OPERAND_USE_RT;
                    ctl.alu_srca = ALU_SRCA_SHAMT;
                end
                case (fn)
                    SLL, SLLV: ctl.alu_op = ALU_SHIFT_LEFT;
                    SRA, SRAV: ctl.alu_op = ALU_SHIFT_ARITH_RIGHT;
                    default:   ctl.alu_op = ALU_SHIFT_LOGIC_RIGHT;
                endcase
                if (fn == SRL && rotate_bit)
                    ctl.alu_op = ALU_ROTATE_RIGHT;
            end

            ADDU, SUBU, AND, OR, XOR, NOR, SLT, SLTU: begin
                ctl = rd_write(ctl, REG_SRC_ALU);
                ctl.opd_use = OPERAND_USE_RS_RT;
                case (fn)
                    SUBU:    ctl.alu_op = ALU_SUB;
                    AND:     ctl.alu_op = ALU_AND;
                    OR:      ctl.alu_op = ALU_OR;
                    XOR:     ctl.alu_op = ALU_XOR;
                    NOR:     ctl.alu_op = ALU_NOR;
                    SLT:     ctl.alu_op = ALU_SLT;
                    SLTU:    ctl.alu_op = ALU_SLTU;
                    default: ctl.alu_op = ALU_ADD;
                endcase
            end

            JR, JALR: begin
                ctl.opd_use = OPERAND_USE_RS;
                ctl.pc_src = PC_SRC_REGISTER;
                if (fn == JALR)
                    ctl = rd_write(ctl, REG_SRC_PCADD4);  // link goes to $rd
            end

            MOVZ, MOVN: begin
                // the alu compares $rt with zero and the flag gates the write of $rs
                ctl = rd_write(ctl, REG_SRC_RS);
                ctl.opd_use = OPERAND_USE_RS_RT;
                ctl.alu_op = ALU_SUB;
                ctl.alu_srca = ALU_SRCA_RT;
                ctl.alu_srcb = ALU_SRCB_ZERO;
                ctl.write_cond = REG_WRITE_WHEN_FLAG;
                ctl.flag_sel = (fn == MOVZ) ? FLAG_EQ : FLAG_NE;
            end

            MFHI: ctl = rd_write(ctl, REG_SRC_HI);
            MFLO: ctl = rd_write(ctl, REG_SRC_LO);

            MTHI, MTLO: begin
                ctl.opd_use = OPERAND_USE_RS;
                ctl.hilo_src = HILO_SRC_RS;
                ctl.write_hi = (fn == MTHI);
                ctl.write_lo = (fn == MTLO);
            end

            MULT, MULTU, DIV, DIVU: begin
                if (HAS_MULDIV) begin
                    ctl.opd_use = OPERAND_USE_RS_RT;
                    ctl.hilo_src = HILO_SRC_MULDIV;
                    ctl.write_hi = 1'b1;
                    ctl.write_lo = 1'b1;
                    case (fn)
                        MULT:    ctl.muldiv = MULDIV_MULT;
                        MULTU:   ctl.muldiv = MULDIV_MULTU;
                        DIV:     ctl.muldiv = MULDIV_DIV;
                        default: ctl.muldiv = MULDIV_DIVU;
                    endcase
                end else begin
                    ctl = reserved_control();  // no unit to run them on
                end
            end

            SYSCALL: begin
                ctl.pc_src = PC_SRC_EXCEPTION;
                ctl.exc_chk = EXC_SYSCALL;
            end

            default: ctl = reserved_control();
        endcase
    end

endmodule

`default_nettype wire

//--- hw/itype_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module itype_decoder import mips_isa_pkg::*, ctl_sig_pkg::*; (
    input  instr_fields_t fields,
    output control_t      ctl
);

    always_comb begin
        ctl = default_control();

        case (fields.op)
            ADDIU, SLTI, SLTIU, ANDI, ORI, XORI: begin
                ctl.opd_use = OPERAND_USE_RS;
                ctl.reg_dst = REG_DST_RT;
                ctl.reg_src = REG_SRC_ALU;
                ctl.reg_write = 1'b1;
                // arithmetic and compares sign extend, logic ops zero extend
                if (fields.op inside {ADDIU, SLTI, SLTIU})
                    ctl.alu_srcb = ALU_SRCB_IMM_SIGNED;
                else
                    ctl.alu_srcb = ALU_SRCB_IMM_ZERO;
                case (fields.op)
                    SLTI:    ctl.alu_op = ALU_SLT;
                    SLTIU:   ctl.alu_op = ALU_SLTU;
                    ANDI:    ctl.alu_op = ALU_AND;
                    ORI:     ctl.alu_op = ALU_OR;
                    XORI:    ctl.alu_op = ALU_XOR;
                    default: ctl.alu_op = ALU_ADD;
                endcase
            end

            LUI: begin
                ctl.alu_op = ALU_LUI;  // reads no register
                ctl.alu_srcb = ALU_SRCB_IMM_ZERO;
                ctl.reg_dst = REG_DST_RT;
                ctl.reg_src = REG_SRC_ALU;
                ctl.reg_write = 1'b1;
            end

            LW, SW: begin
                ctl.alu_op = ALU_ADD;  // base plus offset
                ctl.alu_srcb = ALU_SRCB_IMM_SIGNED;
                if (fields.op == LW) begin
                    ctl.opd_use = OPERAND_USE_RS;
                    ctl.mem_op = MEM_OP_LOAD;
                    ctl.reg_dst = REG_DST_RT;
                    ctl.reg_src = REG_SRC_MEM;
                    ctl.reg_write = 1'b1;
                end else begin
                    ctl.opd_use = OPERAND_USE_RS_RT;
                    ctl.mem_op = MEM_OP_STORE;
                end
            end

            BEQ, BNE: begin
                ctl.opd_use = OPERAND_USE_RS_RT;
                ctl.pc_src = PC_SRC_BRANCH;
                ctl.alu_op = ALU_SUB;
                ctl.flag_sel = (fields.op == BEQ) ? FLAG_EQ : FLAG_NE;
            end

            J, JAL: begin
                ctl.pc_src = PC_SRC_JUMP;
                if (fields.op == JAL) begin
                    ctl.reg_dst = REG_DST_R31;  // return address into $ra
                    ctl.reg_src = REG_SRC_PCADD4;
                    ctl.reg_write = 1'b1;
                end
            end

            // SPECIAL goes to the r-type path, so it lands here only by mistake
            default: ctl = reserved_control();
        endcase
    end

endmodule

`default_nettype wire

//--- hw/instr_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module instr_decoder import mips_isa_pkg::*, ctl_sig_pkg::*; #(
    parameter bit HAS_MULDIV = 1'b1
) (
    input  logic [31:0]    instr,
    dec_if.producer        dec
);

    instr_fields_t fields;
    control_t      r_ctl;
    control_t      i_ctl;
    control_t      ctl;

    assign fields = instr_fields_t'(instr);

    rtype_decoder #(.HAS_MULDIV(HAS_MULDIV)) rdec0 (
        .fields     (fields),
        .rotate_bit (instr[21]),  // rotr shares the srl funct
        .ctl        (r_ctl)
    );

    itype_decoder idec0 (
        .fields (fields),
        .ctl    (i_ctl)
    );

    assign ctl = (fields.op == SPECIAL) ? r_ctl : i_ctl;

    always_comb begin
        case (ctl.reg_dst)
            REG_DST_RD:  dec.dest = fields.low.r.rd;
            REG_DST_RT:  dec.dest = fields.rt;
            REG_DST_R31: dec.dest = 5'd31;
            default:     dec.dest = 5'd0;
        endcase
    end

    assign dec.ctl = ctl;
    assign dec.rs = fields.rs;
    assign dec.rt = fields.rt;
    assign dec.shamt = fields.low.r.shamt;
    assign dec.imm = fields.low.imm;

endmodule

`default_nettype wire

//--- hw/decode_pipe_reg.sv
`timescale 1ns/10ps
`default_nettype none

module decode_pipe_reg import ctl_sig_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    output logic        in_ready,
    dec_if.consumer     dec,
    output logic        out_valid,
    input  logic        out_ready,
    output control_t    q_ctl,
    output logic [4:0]  q_rs,
    output logic [4:0]  q_rt,
    output logic [4:0]  q_dest,
    output logic [4:0]  q_shamt,
    output logic [15:0] q_imm
);

    logic load;

    // accept when empty or when the held entry leaves this cycle
    assign in_ready = !out_valid || out_ready;
    assign load = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;  // drains to empty when nothing comes in
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            q_ctl <= dec.ctl;
            q_rs <= dec.rs;
            q_rt <= dec.rt;
            q_dest <= dec.dest;
            q_shamt <= dec.shamt;
            q_imm <= dec.imm;
        end
    end

endmodule

`default_nettype wire

//--- hw/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage import ctl_sig_pkg::*; #(
    parameter bit HAS_MULDIV = 1'b1
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    output logic        in_ready,
    input  logic [31:0] instr,
    output logic        out_valid,
    input  logic        out_ready,
    output opd_use_e    opd_use,
    output pc_src_e     pc_src,
    output exc_chk_e    exc_chk,
    output alu_op_e     alu_op,
    output alu_srca_e   alu_srca,
    output alu_srcb_e   alu_srcb,
    output reg_src_e    reg_src,
    output write_cond_e write_cond,
    output flag_sel_e   flag_sel,
    output hilo_src_e   hilo_src,
    output muldiv_e     muldiv,
    output mem_op_e     mem_op,
    output logic        reg_write,
    output logic        write_hi,
    output logic        write_lo,
    output logic [4:0]  rs,
    output logic [4:0]  rt,
    output logic [4:0]  dest,
    output logic [4:0]  shamt,
    output logic [15:0] imm
);

    control_t q_ctl;

    dec_if dec0 ();

    instr_decoder #(.HAS_MULDIV(HAS_MULDIV)) idec0 (
        .instr (instr),
        .dec   (dec0.producer)
    );

    decode_pipe_reg preg0 (
        .clk (clk), .rst (rst),
        .in_valid (in_valid), .in_ready (in_ready),
        .dec (dec0.consumer),
        .out_valid (out_valid), .out_ready (out_ready),
        .q_ctl (q_ctl), .q_rs (rs), .q_rt (rt),
        .q_dest (dest), .q_shamt (shamt), .q_imm (imm)
    );

    // reg_dst is already folded into dest, so it has no port of its own
    assign opd_use = q_ctl.opd_use;
    assign pc_src = q_ctl.pc_src;
    assign exc_chk = q_ctl.exc_chk;
    assign alu_op = q_ctl.alu_op;
    assign alu_srca = q_ctl.alu_srca;
    assign alu_srcb = q_ctl.alu_srcb;
    assign reg_src = q_ctl.reg_src;
    assign write_cond = q_ctl.write_cond;
    assign flag_sel = q_ctl.flag_sel;
    assign hilo_src = q_ctl.hilo_src;
    assign muldiv = q_ctl.muldiv;
    assign mem_op = q_ctl.mem_op;
    assign reg_write = q_ctl.reg_write;
    assign write_hi = q_ctl.write_hi;
    assign write_lo = q_ctl.write_lo;

endmodule

`default_nettype wire

//--- dv/decode_props.sv
`timescale 1ns/10ps
`default_nettype none

module decode_props import ctl_sig_pkg::*; (
    input logic        clk,
    input logic        rst,
    input logic        in_valid,
    input logic        in_ready,
    input logic        out_valid,
    input logic        out_ready,
    input control_t    q_ctl,
    input logic [4:0]  q_rs,
    input logic [4:0]  q_rt,
    input logic [4:0]  q_dest,
    input logic [4:0]  q_shamt,
    input logic [15:0] q_imm
);

    int fail_count = 0;

    a_reset_empties: assert property (@(posedge clk) rst |=> !out_valid)
        else begin
            fail_count++;
            $error("out_valid is high in the cycle after reset");
        end

    // a held entry must not change or vanish while the consumer stalls
    a_hold_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid &&
        $stable({q_ctl, q_rs, q_rt, q_dest, q_shamt, q_imm}))
        else begin
            fail_count++;
            $error("stalled output changed before it was taken");
        end

    // an accepted instruction is on the output one cycle later
    a_accept_shows: assert property (@(posedge clk) disable iff (rst)
        in_valid && in_ready |=> out_valid)
        else begin
            fail_count++;
            $error("an accepted instruction did not reach the output");
        end

endmodule

`default_nettype wire

//--- dv/decode_tb.sv
`timescale 1ns/10ps
`default_nettype none

module decode_tb import ctl_sig_pkg::*; ();

    typedef struct packed {
        control_t    ctl;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  dest;
        logic [4:0]  shamt;
        logic [15:0] imm;
    } expect_t;

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic        in_ready;
    logic [31:0] instr;
    logic        out_valid;
    logic        out_ready;
    opd_use_e    opd_use;
    pc_src_e     pc_src;
    exc_chk_e    exc_chk;
    alu_op_e     alu_op;
    alu_srca_e   alu_srca;
    alu_srcb_e   alu_srcb;
    reg_src_e    reg_src;
    write_cond_e write_cond;
    flag_sel_e   flag_sel;
    hilo_src_e   hilo_src;
    muldiv_e     muldiv;
    mem_op_e     mem_op;
    logic        reg_write;
    logic        write_hi;
    logic        write_lo;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  dest;
    logic [4:0]  shamt;
    logic [15:0] imm;

    integer      seed;
    integer      cyc;
    integer      limit;
    integer      n_out;
    logic        stall_en;
    logic        tight;  // out_ready held high, latency and throughput are checked
    logic [31:0] stim[$];
    logic [31:0] exp_q[$];
    integer      acc_q[$];

    decode_stage #(.HAS_MULDIV(1'b1)) dut0 (.*);

    bind decode_pipe_reg decode_props props0 (
        .clk(clk), .rst(rst), .in_valid(in_valid), .in_ready(in_ready),
        .out_valid(out_valid), .out_ready(out_ready), .q_ctl(q_ctl), .q_rs(q_rs),
        .q_rt(q_rt), .q_dest(q_dest), .q_shamt(q_shamt), .q_imm(q_imm)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = !clk;
    end

    // ##################################################
    // reference decode
    // ##################################################

    function automatic control_t with_write(control_t c, reg_dst_e d, reg_src_e s);
        control_t r;
        r = c;
        r.reg_dst = d;
        r.reg_src = s;
        r.reg_write = 1'b1;
        return r;
    endfunction

    function automatic alu_op_e shift_kind(logic [5:0] fn, logic rot);
        if (fn[1:0] == 2'b00)
            return ALU_SHIFT_LEFT;
        else if (fn[1:0] == 2'b11)
            return ALU_SHIFT_ARITH_RIGHT;
        else if (rot)
            return ALU_ROTATE_RIGHT;
        return ALU_SHIFT_LOGIC_RIGHT;
    endfunction

    function automatic expect_t ref_decode(logic [31:0] w);
        expect_t    e;
        control_t   c;
        logic [5:0] op;
        logic [5:0] fn;
        op = w[31:26];
        fn = w[5:0];
        c = '{OPERAND_USE_NONE, PC_SRC_SEQ, EXC_NONE, ALU_ADD, ALU_SRCA_RS, ALU_SRCB_RT,
              REG_DST_NONE, REG_SRC_ALU, REG_WRITE_ALWAYS, FLAG_EQ, HILO_SRC_RS,
              MULDIV_NCARE, MEM_OP_NONE, 1'b0, 1'b0, 1'b0};
        if (op == 6'h00) begin
            case (fn)
                6'h00, 6'h02, 6'h03: begin  // shift by the shamt field
                    c = with_write(c, REG_DST_RD, REG_SRC_ALU);
                    c.opd_use = OPERAND_USE_RT;
                    c.alu_srca = ALU_SRCA_SHAMT;
                    c.alu_op = shift_kind(fn, w[21]);
                end
                6'h04, 6'h06, 6'h07: begin
                    c = with_write(c, REG_DST_RD, REG_SRC_ALU);
                    c.opd_use = OPERAND_USE_RS_RT;
                    c.alu_op = shift_kind(fn, 1'b0);
                end
                6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b: begin
                    c = with_write(c, REG_DST_RD, REG_SRC_ALU);
                    c.opd_use = OPERAND_USE_RS_RT;
                    case (fn)
                        6'h23:   c.alu_op = ALU_SUB;
                        6'h24:   c.alu_op = ALU_AND;
                        6'h25:   c.alu_op = ALU_OR;
                        6'h26:   c.alu_op = ALU_XOR;
                        6'h27:   c.alu_op = ALU_NOR;
                        6'h2a:   c.alu_op = ALU_SLT;
                        6'h2b:   c.alu_op = ALU_SLTU;
                        default: c.alu_op = ALU_ADD;
                    endcase
                end
                6'h08, 6'h09: begin
                    if (fn == 6'h09)
                        c = with_write(c, REG_DST_RD, REG_SRC_PCADD4);
                    c.opd_use = OPERAND_USE_RS;
                    c.pc_src = PC_SRC_REGISTER;
                end
                6'h0a, 6'h0b: begin  // movz, movn test rt against zero
                    c = with_write(c, REG_DST_RD, REG_SRC_RS);
                    c.opd_use = OPERAND_USE_RS_RT;
                    c.alu_op = ALU_SUB;
                    c.alu_srca = ALU_SRCA_RT;
                    c.alu_srcb = ALU_SRCB_ZERO;
                    c.write_cond = REG_WRITE_WHEN_FLAG;
                    if (fn == 6'h0b)
                        c.flag_sel = FLAG_NE;
                end
                6'h10:   c = with_write(c, REG_DST_RD, REG_SRC_HI);
                6'h12:   c = with_write(c, REG_DST_RD, REG_SRC_LO);
                6'h11, 6'h13: begin
                    c.opd_use = OPERAND_USE_RS;
                    c.write_hi = (fn == 6'h11);
                    c.write_lo = (fn == 6'h13);
                end
                6'h18, 6'h19, 6'h1a, 6'h1b: begin
                    c.opd_use = OPERAND_USE_RS_RT;
                    c.hilo_src = HILO_SRC_MULDIV;
                    c.write_hi = 1'b1;
                    c.write_lo = 1'b1;
                    case (fn)
                        6'h18:   c.muldiv = MULDIV_MULT;
                        6'h19:   c.muldiv = MULDIV_MULTU;
                        6'h1a:   c.muldiv = MULDIV_DIV;
                        default: c.muldiv = MULDIV_DIVU;
                    endcase
                end
                6'h0c: begin
                    c.pc_src = PC_SRC_EXCEPTION;
                    c.exc_chk = EXC_SYSCALL;
                end
                default: begin
                    c.pc_src = PC_SRC_EXCEPTION;
                    c.exc_chk = EXC_RESERVED;
                end
            endcase
        end else begin
            case (op)
                6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e: begin
                    c = with_write(c, REG_DST_RT, REG_SRC_ALU);
                    c.opd_use = OPERAND_USE_RS;
                    if (op < 6'h0c)
                        c.alu_srcb = ALU_SRCB_IMM_SIGNED;
                    else
                        c.alu_srcb = ALU_SRCB_IMM_ZERO;
                    case (op)
                        6'h0a:   c.alu_op = ALU_SLT;
                        6'h0b:   c.alu_op = ALU_SLTU;
                        6'h0c:   c.alu_op = ALU_AND;
                        6'h0d:   c.alu_op = ALU_OR;
                        6'h0e:   c.alu_op = ALU_XOR;
                        default: c.alu_op = ALU_ADD;
                    endcase
                end
                6'h0f: begin
                    c = with_write(c, REG_DST_RT, REG_SRC_ALU);
                    c.alu_op = ALU_LUI;
                    c.alu_srcb = ALU_SRCB_IMM_ZERO;
                end
                6'h23: begin
                    c = with_write(c, REG_DST_RT, REG_SRC_MEM);
                    c.opd_use = OPERAND_USE_RS;
                    c.alu_srcb = ALU_SRCB_IMM_SIGNED;
                    c.mem_op = MEM_OP_LOAD;
                end
                6'h2b: begin
                    c.opd_use = OPERAND_USE_RS_RT;
                    c.alu_srcb = ALU_SRCB_IMM_SIGNED;
                    c.mem_op = MEM_OP_STORE;
                end
                6'h04, 6'h05: begin
                    c.opd_use = OPERAND_USE_RS_RT;
                    c.pc_src = PC_SRC_BRANCH;
                    c.alu_op = ALU_SUB;
                    if (op == 6'h05)
                        c.flag_sel = FLAG_NE;
                end
                6'h02, 6'h03: begin
                    if (op == 6'h03)
                        c = with_write(c, REG_DST_R31, REG_SRC_PCADD4);
                    c.pc_src = PC_SRC_JUMP;
                end
                default: begin
                    c.pc_src = PC_SRC_EXCEPTION;
                    c.exc_chk = EXC_RESERVED;
                end
            endcase
        end
        case (c.reg_dst)
            REG_DST_RD:  e.dest = w[15:11];
            REG_DST_RT:  e.dest = w[20:16];
            REG_DST_R31: e.dest = 5'd31;
            default:     e.dest = 5'd0;
        endcase
        e.ctl = c;
        e.rs = w[25:21];
        e.rt = w[20:16];
        e.shamt = w[10:6];
        e.imm = w[15:0];
        return e;
    endfunction

    // ##################################################
    // checking
    // ##################################################

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got === want) else begin
            $display("mismatch at %0t: %s expected %0h got %0h", $time, name, want, got);
            $display("*** TEST FAILED ***");
            $fatal(1, "output check failed");
        end
    endtask

    task automatic compare_output(input logic [31:0] w);
        expect_t e;
        e = ref_decode(w);
        check_value("opd_use", opd_use, e.ctl.opd_use);
        check_value("pc_src", pc_src, e.ctl.pc_src);
        check_value("exc_chk", exc_chk, e.ctl.exc_chk);
        check_value("alu_op", alu_op, e.ctl.alu_op);
        check_value("alu_srca", alu_srca, e.ctl.alu_srca);
        check_value("alu_srcb", alu_srcb, e.ctl.alu_srcb);
        check_value("reg_src", reg_src, e.ctl.reg_src);
        check_value("write_cond", write_cond, e.ctl.write_cond);
        check_value("flag_sel", flag_sel, e.ctl.flag_sel);
        check_value("hilo_src", hilo_src, e.ctl.hilo_src);
        check_value("muldiv", muldiv, e.ctl.muldiv);
        check_value("mem_op", mem_op, e.ctl.mem_op);
        check_value("reg_write", reg_write, e.ctl.reg_write);
        check_value("write_hi", write_hi, e.ctl.write_hi);
        check_value("write_lo", write_lo, e.ctl.write_lo);
        check_value("rs", rs, e.rs);
        check_value("rt", rt, e.rt);
        check_value("dest", dest, e.dest);
        check_value("shamt", shamt, e.shamt);
        check_value("imm", imm, e.imm);
    endtask

    always @(posedge clk) begin
        integer t_acc;
        if (!rst && out_valid && out_ready) begin
            assert (exp_q.size() > 0) else begin
                $display("an output was handed over at %0t with nothing pending", $time);
                $display("*** TEST FAILED ***");
                $fatal(1, "unexpected output");
            end
            t_acc = acc_q.pop_front();
            if (tight)
                check_value("latency", cyc - t_acc, 1);
            compare_output(exp_q.pop_front());
            n_out <= n_out + 1;
        end
        if (!rst && in_valid) begin
            assert (!tight || in_ready) else begin
                $display("input stalled at %0t although out_ready was held high", $time);
                $display("*** TEST FAILED ***");
                $fatal(1, "throughput check failed");
            end
            if (in_ready) begin
                exp_q.push_back(instr);
                acc_q.push_back(cyc);
            end
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (stall_en)
            out_ready <= ($random(seed) & 3) != 0;  // ready three cycles in four
        else
            out_ready <= 1'b1;
    end

    always @(posedge clk) begin
        if (cyc > limit) begin
            $display("timeout: %0d outputs seen after %0d cycles", n_out, cyc);
            $display("*** TEST FAILED ***");
            $fatal(1, "watchdog expired");
        end
    end

    always @(posedge clk) begin
        assert (dut0.preg0.props0.fail_count == 0) else begin
            $display("a handshake property failed before %0t", $time);
            $display("*** TEST FAILED ***");
            $fatal(1, "handshake property failed");
        end
    end

    // ##################################################
    // stimulus
    // ##################################################

    function automatic logic [31:0] rword(logic [5:0] fn, logic [4:0] a, logic [4:0] b,
                                          logic [4:0] d, logic [4:0] sh);
        return {6'h00, a, b, d, sh, fn};
    endfunction

    task automatic send(input logic [31:0] w);
        in_valid <= 1'b1;
        instr <= w;
        @(posedge clk);
        while (!in_ready)
            @(posedge clk);
    endtask

    initial begin
        integer      tight_from;
        logic [31:0] w;
        seed = 11840;
        clk = 1'b0;
        rst = 1'b1;
        in_valid = 1'b0;
        instr = 32'd0;
        out_ready = 1'b0;
        stall_en = 1'b1;
        tight = 1'b0;
        cyc = 0;
        n_out = 0;
        // every funct and every opcode, so reserved codes come along too
        for (int i = 0; i < 64; i++)
            stim.push_back(rword(i[5:0], 5'(i * 6), 5'(i * 3 + 1), 5'(31 - i), 5'(i * 5)));
        stim.push_back(rword(6'h02, 5'd0, 5'd9, 5'd10, 5'd4));  // srl
        stim.push_back(rword(6'h02, 5'd1, 5'd9, 5'd10, 5'd4));  // rotr
        for (int i = 1; i < 64; i++)
            stim.push_back({i[5:0], 5'(i * 7), 5'(i * 11 + 2), 4'(i), 12'(i * 341)});
        for (int i = 0; i < 84; i++) begin
            w = $random(seed);
            if (w[31])
                w[31:26] = 6'h00;
            stim.push_back(w);
        end
        tight_from = stim.size() - 24;
        limit = stim.size() * 20 + 100;

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < tight_from; i++)
            send(stim[i]);
        in_valid <= 1'b0;
        while (n_out < tight_from)
            @(posedge clk);

        stall_en <= 1'b0;
        repeat (2) @(posedge clk);
        tight <= 1'b1;
        for (int i = tight_from; i < stim.size(); i++)
            send(stim[i]);
        in_valid <= 1'b0;
        while (n_out < stim.size())
            @(posedge clk);
        repeat (2) @(posedge clk);

        if (exp_q.size() == 0 && !out_valid && dut0.preg0.props0.fail_count == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("%0d left pending, %0d handshake property failures", exp_q.size(),
                     dut0.preg0.props0.fail_count);
            $display("*** TEST FAILED ***");
            $fatal(1, "end of run checks failed");
        end
    end

endmodule

`default_nettype wire

//--- compile.f
hw/mips_isa_pkg.sv
hw/ctl_sig_pkg.sv
hw/dec_if.sv
hw/rtype_decoder.sv
hw/itype_decoder.sv
hw/instr_decoder.sv
hw/decode_pipe_reg.sv
hw/decode_stage.sv
dv/decode_props.sv
dv/decode_tb.sv
